// ==== all.f ====
+incdir+tb
rtl/capture_pkg.sv
rtl/capture_ctrl.sv
rtl/ring_memory.sv
rtl/readout_ctrl.sv
rtl/trigger_buffer.sv
tb/trigger_buffer_tb.sv

// ==== rtl/capture_ctrl.sv ====
// Write side of the capture buffer; accepts input beats, applies the trigger rule and raises full
module capture_ctrl (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               enable,
    input  logic                               trigger,
    input  logic [capture_pkg::addr_width-1:0] trigger_point,
    input  logic                               in_valid,
    input  logic                               readout_done,
    output logic                               in_ready,
    output logic                               wr_en,
    output logic [capture_pkg::addr_width-1:0] wr_addr,
    output logic                               full,
    output logic [capture_pkg::addr_width-1:0] start_addr
);
    import capture_pkg::*;

    capture_state_t        state;
    logic [addr_width-1:0] wr_ptr;
    // Counts beats accepted since arming and saturates so it never wraps below trigger_point
    logic [addr_width-1:0] fill_count;
    // Post-trigger beats still to be accepted
    logic [addr_width:0]   post_count;
    logic [addr_width:0]   post_len;
    logic                  accept;
    logic                  trig_accept;
    logic                  window_close;

    assign full     = (state == full_wait);
    assign in_ready = enable && !full;
    assign accept   = in_valid && in_ready;
    assign wr_en    = accept;
    assign wr_addr  = wr_ptr;

    // Triggers count only once enough history has been recorded since arming
    assign trig_accept = trigger && enable && (state == armed) && (fill_count >= trigger_point);

    // The post-trigger length comes from trigger_point at the trigger edge
    assign post_len = (addr_width + 1)'(buffer_depth) - {1'b0, trigger_point};

    // The window closes on the write of its last post-trigger beat
    assign window_close = accept && ((trig_accept && (post_len == 1)) ||
                                     ((state == post_trigger) && (post_count == 1)));

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state      <= armed;
            wr_ptr     <= '0;
            fill_count <= '0;
            post_count <= '0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            case (state)
                armed: begin
                    if (window_close) begin
                        state <= full_wait;
                    end else if (trig_accept) begin
                        // A beat taken on the trigger edge is the first post-trigger beat
                        state      <= post_trigger;
                        post_count <= accept ? post_len - 1'b1 : post_len;
                    end else if (accept && (fill_count != '1)) begin
                        fill_count <= fill_count + 1'b1;
                    end
                end
                post_trigger: begin
                    if (window_close) begin
                        state <= full_wait;
                    end
                    if (accept) begin
                        post_count <= post_count - 1'b1;
                    end
                end
                full_wait: begin
                    // Re-arm with a fresh history once playback has finished
                    if (readout_done) begin
                        state      <= armed;
                        fill_count <= '0;
                    end
                end
                default: begin
                    state <= armed;
                end
            endcase
        end
    end

    // After the last write the oldest beat is the one in the next slot of the ring
    always_ff @(posedge clock) begin
        if (window_close) begin
            start_addr <= wr_ptr + 1'b1;
        end
    end

    // While the window is held the write pointer still sits on its oldest beat
    a_no_write_when_full: assert property (
        @(posedge clock) disable iff (!rst_n)
        full |-> (wr_ptr == start_addr)
    ) else $error("capture_ctrl: write while full");

    // A zero trigger point would make the window longer than the memory
    a_trigger_point_valid: assert property (
        @(posedge clock) disable iff (!rst_n)
        trig_accept |-> (trigger_point != '0)
    ) else $error("capture_ctrl: trigger accepted with trigger_point of 0");

endmodule

// ==== rtl/capture_pkg.sv ====
// Shared sizes, beat format and FSM state types for the triggered capture buffer; import where needed
package capture_pkg;

    // Memory address width; the ring holds one full capture window
    localparam int addr_width = 6;
    localparam int buffer_depth = 1 << addr_width;

    // Field widths of one stream beat
    localparam int data_width = 32;
    localparam int dest_width = 4;
    localparam int user_width = 4;

    // One beat as it travels on both streams and through the memory
    typedef struct packed {
        logic [data_width-1:0] data;
        logic [dest_width-1:0] dest;
        logic [user_width-1:0] user;
    } stream_beat_t;

    // Write side: wait for a trigger, fill the rest of the window, hold until played out
    typedef enum logic [1:0] {
        armed        = 2'd0,
        post_trigger = 2'd1,
        full_wait    = 2'd2
    } capture_state_t;

    // Read side: wait for a full window, issue the first read, then stream
    typedef enum logic [1:0] {
        idle   = 2'd0,
        fetch  = 2'd1,
        stream = 2'd2
    } readout_state_t;

endpackage

// ==== rtl/readout_ctrl.sv ====
// Read side of the capture buffer; plays the stored window out oldest first with back-pressure
module readout_ctrl (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               full,
    input  logic [capture_pkg::addr_width-1:0] start_addr,
    input  capture_pkg::stream_beat_t          rd_beat,
    input  logic                               out_ready,
    output logic [capture_pkg::addr_width-1:0] rd_addr,
    output capture_pkg::stream_beat_t          out_beat,
    output logic                               out_valid,
    output logic                               readout_done
);
    import capture_pkg::*;

    readout_state_t        state;
    logic [addr_width-1:0] rd_ptr;
    logic [addr_width:0]   issue_count;
    logic [addr_width:0]   xfer_count;
    // rd_beat holds a wanted beat this cycle
    logic                  data_valid;
    logic                  skid_valid;
    stream_beat_t          skid_beat;
    logic                  xfer;
    logic                  last_xfer;
    logic                  pipe_empty;
    logic                  issue;

    // Only one beat waits at a time, in the skid entry or on the memory port
    assign out_valid = skid_valid || data_valid;
    assign out_beat  = skid_valid ? skid_beat : rd_beat;
    assign rd_addr   = rd_ptr;

    assign xfer      = out_valid && out_ready;
    assign last_xfer = xfer && (xfer_count == (addr_width + 1)'(buffer_depth - 1));

    // True when no beat is left waiting after this edge, so a new read cannot collide
    assign pipe_empty = xfer || !out_valid;

    // The memory port is overwritten every edge, so a read is only issued into a free slot
    assign issue = (state == fetch) ||
                   ((state == stream) && pipe_empty &&
                    (issue_count != (addr_width + 1)'(buffer_depth)));

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state        <= idle;
            rd_ptr       <= '0;
            issue_count  <= '0;
            xfer_count   <= '0;
            data_valid   <= 1'b0;
            skid_valid   <= 1'b0;
            readout_done <= 1'b0;
        end else begin
            readout_done <= last_xfer;
            data_valid   <= issue;

            if (issue) begin
                rd_ptr      <= rd_ptr + 1'b1;
                issue_count <= issue_count + 1'b1;
            end

            if (xfer) begin
                xfer_count <= xfer_count + 1'b1;
            end

            // A stalled beat on the memory port moves into the skid entry
            if (skid_valid) begin
                if (xfer) begin
                    skid_valid <= 1'b0;
                end
            end else if (data_valid && !xfer) begin
                skid_valid <= 1'b1;
            end

            case (state)
                idle: begin
                    // full is still high on the cycle of the done pulse
                    if (full && !readout_done) begin
                        state       <= fetch;
                        rd_ptr      <= start_addr;
                        issue_count <= '0;
                        xfer_count  <= '0;
                    end
                end
                fetch: begin
                    state <= stream;
                end
                stream: begin
                    if (last_xfer) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (!skid_valid && data_valid && !xfer) begin
            skid_beat <= rd_beat;
        end
    end

    // A beat offered to a stalled sink stays put until it is taken
    a_stable_when_stalled: assert property (
        @(posedge clock) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
    ) else $error("readout_ctrl: out_beat changed under back-pressure");

    // The done pulse follows the final transfer with no beat left to offer
    a_done_after_transfer: assert property (
        @(posedge clock) disable iff (!rst_n)
        readout_done |-> ($past(out_valid && out_ready) && !out_valid)
    ) else $error("readout_ctrl: readout_done without a final transfer");

endmodule

// ==== rtl/ring_memory.sv ====
// Circular beat storage for the capture buffer; one write port, one registered read port
module ring_memory (
    input  logic                               clock,
    input  logic                               wr_en,
    input  logic [capture_pkg::addr_width-1:0] wr_addr,
    input  capture_pkg::stream_beat_t          wr_beat,
    input  logic [capture_pkg::addr_width-1:0] rd_addr,
    output capture_pkg::stream_beat_t          rd_beat
);
    import capture_pkg::*;

    // One slot per beat of a capture window
    stream_beat_t mem [buffer_depth];

    // Writes land on the edge the input beat is accepted
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    // The read port is always active
    // Data for an address shows up one cycle after it is presented
    always_ff @(posedge clock) begin
        rd_beat <= mem[rd_addr];
    end

endmodule

// ==== rtl/trigger_buffer.sv ====
// Top level of the triggered capture buffer; chains write control, ring memory and readout
module trigger_buffer (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               enable,
    input  logic                               trigger,
    input  logic [capture_pkg::addr_width-1:0] trigger_point,
    output logic                               full,
    input  capture_pkg::stream_beat_t          in_beat,
    input  logic                               in_valid,
    output logic                               in_ready,
    output capture_pkg::stream_beat_t          out_beat,
    output logic                               out_valid,
    input  logic                               out_ready
);
    import capture_pkg::*;

    logic                  wr_en;
    logic [addr_width-1:0] wr_addr;
    logic [addr_width-1:0] start_addr;
    logic [addr_width-1:0] rd_addr;
    stream_beat_t          rd_beat;
    logic                  readout_done;

    // Accepts input beats and decides when the window is complete
    capture_ctrl i_capture_ctrl (
        .clock         (clock),
        .rst_n         (rst_n),
        .enable        (enable),
        .trigger       (trigger),
        .trigger_point (trigger_point),
        .in_valid      (in_valid),
        .readout_done  (readout_done),
        .in_ready      (in_ready),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .full          (full),
        .start_addr    (start_addr)
    );

    // Input beats go straight into the ring at the write pointer
    ring_memory i_ring_memory (
        .clock   (clock),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_beat (in_beat),
        .rd_addr (rd_addr),
        .rd_beat (rd_beat)
    );

    // Plays the window out once full is raised, then hands control back
    readout_ctrl i_readout_ctrl (
        .clock        (clock),
        .rst_n        (rst_n),
        .full         (full),
        .start_addr   (start_addr),
        .rd_beat      (rd_beat),
        .out_ready    (out_ready),
        .rd_addr      (rd_addr),
        .out_beat     (out_beat),
        .out_valid    (out_valid),
        .readout_done (readout_done)
    );

endmodule

// ==== tb/capture_model.svh ====
// Reference model of the capture buffer; included into the testbench module body after the import
`ifndef capture_model_svh
`define capture_model_svh

// Last buffer_depth beats accepted, oldest at the front
stream_beat_t hist_q[$];
// Window frozen when full rises, in expected playback order
stream_beat_t window_q[$];
int arm_count;
bit m_full;
bit m_post;
int post_left;
int m_trigger_point;
int out_index;
bit done_pending;
int captures_done;

task automatic model_reset();
    hist_q.delete();
    window_q.delete();
    arm_count = 0;
    m_full = 0;
    m_post = 0;
    post_left = 0;
    m_trigger_point = 0;
    out_index = 0;
    done_pending = 0;
    captures_done = 0;
endtask

task automatic store_beat(input stream_beat_t beat);
    hist_q.push_back(beat);
    if (hist_q.size() > buffer_depth) begin
        void'(hist_q.pop_front());
    end
endtask

// Input side of one rising edge, given the inputs as they stand before it
task automatic model_input_edge(input bit en, input bit trig, input int tp, input bit valid,
                                input stream_beat_t beat);
    bit accept;
    bit trig_ok;

    if (m_full) begin
        return;
    end
    accept = valid && en;
    trig_ok = trig && en && !m_post && (arm_count >= tp);
    if (trig_ok) begin
        m_post = 1;
        post_left = buffer_depth - tp;
        m_trigger_point = tp;
    end
    if (accept) begin
        store_beat(beat);
        if (m_post) begin
            post_left--;
        end else begin
            arm_count++;
        end
    end
    // The window is complete once the last post-trigger beat is in
    if (m_post && post_left == 0) begin
        m_post = 0;
        m_full = 1;
        window_q = hist_q;
        out_index = 0;
    end
endtask

// Output side of one rising edge; full drops one edge after the last transfer
task automatic model_output_edge(input bit xfer);
    if (done_pending) begin
        done_pending = 0;
        m_full = 0;
        arm_count = 0;
        captures_done++;
        $display("Capture %0d played out, trigger_point %0d", captures_done, m_trigger_point);
    end else if (xfer) begin
        out_index++;
        if (out_index == buffer_depth) begin
            done_pending = 1;
        end
    end
endtask

`endif

// ==== tb/trigger_buffer_tb.sv ====
// Testbench for the triggered capture buffer; random streams and triggers checked against a model
module trigger_buffer_tb;
    import capture_pkg::*;

    localparam int capture_target = 8;
    localparam int cycle_limit = 40000;

    logic                  clock;
    logic                  rst_n;
    logic                  enable;
    logic                  trigger;
    logic [addr_width-1:0] trigger_point;
    logic                  full;
    stream_beat_t          in_beat;
    logic                  in_valid;
    logic                  in_ready;
    stream_beat_t          out_beat;
    logic                  out_valid;
    logic                  out_ready;

    // Input beat still waiting for its transfer, so it must be held
    bit           in_held;
    int           enable_low_left;
    // Output beat stalled at the last sample, with its value
    bit           stall_prev;
    stream_beat_t stall_beat;
    int           cycles;

    `include "capture_model.svh"

    trigger_buffer i_trigger_buffer (
        .clock         (clock),
        .rst_n         (rst_n),
        .enable        (enable),
        .trigger       (trigger),
        .trigger_point (trigger_point),
        .full          (full),
        .in_beat       (in_beat),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .out_beat      (out_beat),
        .out_valid     (out_valid),
        .out_ready     (out_ready)
    );

    always #50 clock = ~clock;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] time %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic stream_beat_t random_beat();
        stream_beat_t beat;
        beat.data = $urandom;
        beat.dest = $urandom;
        beat.user = $urandom;
        return beat;
    endfunction

    // New stimulus for the next edge; a pending input beat keeps its value
    task automatic drive_inputs();
        if (enable_low_left > 0) begin
            enable = 1'b0;
            enable_low_left--;
        end else if ($urandom % 40 == 0) begin
            enable = 1'b0;
            enable_low_left = $urandom % 5;
        end else begin
            enable = 1'b1;
        end
        if (!in_held) begin
            in_valid = ($urandom % 10) < 7;
            in_beat = random_beat();
        end
        // Frequent pulses, so many arrive before enough history is recorded
        trigger = ($urandom % 12) == 0;
        if (trigger) begin
            trigger_point = 1 + ($urandom % (buffer_depth - 1));
        end
        out_ready = ($urandom % 10) < 6;
    endtask

    // Compare outputs between edges, then advance the model over the next edge
    task automatic check_and_step();
        bit exp_ready;
        bit xfer;

        exp_ready = enable && !m_full;
        check_value("full", m_full, full);
        check_value("in_ready", exp_ready, in_ready);
        if (!m_full || out_index == buffer_depth) begin
            check_value("out_valid", 0, out_valid);
        end
        if (stall_prev) begin
            check_value("out_valid", 1, out_valid);
            check_value("out_beat", stall_beat, out_beat);
        end
        stall_prev = out_valid && !out_ready;
        stall_beat = out_beat;

        xfer = out_valid && out_ready;
        if (xfer) begin
            check_value("out_beat", window_q[out_index], out_beat);
        end
        in_held = in_valid && !exp_ready;

        model_input_edge(enable, trigger, trigger_point, in_valid, in_beat);
        model_output_edge(xfer);
    endtask

    initial begin
        void'($urandom(87));
        clock = 1'b0;
        rst_n = 1'b0;
        enable = 1'b1;
        trigger = 1'b0;
        trigger_point = 6'd32;
        in_beat = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        in_held = 0;
        enable_low_left = 0;
        stall_prev = 0;
        stall_beat = '0;
        cycles = 0;
        model_reset();

        repeat (3) @(posedge clock);
        #5;
        rst_n = 1'b1;

        // State straight out of reset
        @(negedge clock);
        check_value("full", 0, full);
        check_value("out_valid", 0, out_valid);
        check_value("in_ready", enable, in_ready);

        @(posedge clock);
        #5;
        drive_inputs();

        while (captures_done < capture_target && cycles < cycle_limit) begin
            @(negedge clock);
            check_and_step();
            @(posedge clock);
            #5;
            drive_inputs();
            cycles++;
        end

        if (captures_done >= capture_target) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("Timeout after %0d cycles with only %0d of %0d captures played out",
                     cycles, captures_done, capture_target);
            $display("TEST FAIL");
            $fatal(1, "Capture sequence did not finish in time");
        end
    end

endmodule
